// File: csr_bridge_pkg.sv
package csr_bridge_pkg;

   // --------------------------------------------------
   // Bus and CSR widths
   // --------------------------------------------------
   localparam int axi_addr_width = 21;
   localparam int data_width     = 32;
   localparam int strb_width     = data_width / 8;
   localparam int id_width       = 4;
   localparam int csr_addr_width = 16;   // Low part of the AXI address

   // Decoded CSR addresses
   localparam logic [csr_addr_width-1:0] csr_addr_ctrl = 16'h0150;
   localparam logic [csr_addr_width-1:0] csr_addr_stat = 16'h0154;
   localparam logic [csr_addr_width-1:0] csr_addr_cfg  = 16'h0158;   // Top of window

   // --------------------------------------------------
   // Channel payloads
   // --------------------------------------------------
   typedef struct packed {
      logic [axi_addr_width-1:0] addr;
      logic [id_width-1:0]       id;
   } aw_req_t;

   typedef aw_req_t ar_req_t;   // Read address has the same layout

   typedef struct packed {
      logic [data_width-1:0] data;
      logic [strb_width-1:0] strb;
   } w_req_t;

   typedef struct packed {
      logic [id_width-1:0] id;
   } b_rsp_t;

   typedef struct packed {
      logic [data_width-1:0] data;
      logic [id_width-1:0]   id;
   } r_rsp_t;

   typedef struct packed {
      logic [csr_addr_width-1:0] addr;
      logic [data_width-1:0]     data;
      logic [strb_width-1:0]     strb;
   } csr_wr_t;

   // Abort sources shared by both channel FSMs
   typedef struct packed {
      logic       cpl_err;
      logic       fifo_err;
      logic [1:0] tx_bresp;   // Nonzero means a failed transmit write
   } err_in_t;

   function automatic logic err_active(input err_in_t e);
      return e.cpl_err || e.fifo_err || (e.tx_bresp != 2'b00);
   endfunction

endpackage

// File: hps_rx_sample.sv
`timescale 1ns/100ps

// One entry register stage for an AXI request channel
module hps_rx_sample #(
   parameter type payload_t = logic
) (
   input  logic     clk,
   input  logic     rst_n,
   input  logic     valid,
   input  payload_t payload,
   output logic     valid_q,
   output payload_t payload_q
);

   // --------------------------------------------------
   // Sample every cycle, FSMs only look at these copies
   // --------------------------------------------------
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         valid_q   <= 1'b0;
         payload_q <= '0;
      end
      else
      begin
         valid_q   <= valid;
         payload_q <= payload;   // Taken regardless of valid
      end
   end

endmodule

// File: csr_wr_fsm.sv
`timescale 1ns/100ps

module csr_wr_fsm (
   input  logic                    clk,
   input  logic                    rst_n,
   input  csr_bridge_pkg::err_in_t err,
   input  logic                    aw_valid_q,
   input  csr_bridge_pkg::aw_req_t aw_q,
   input  logic                    w_valid_q,
   input  csr_bridge_pkg::w_req_t  w_q,
   output logic                    awready,
   output logic                    wready,
   input  logic                    bready,
   output logic                    bvalid,
   output csr_bridge_pkg::b_rsp_t  b,
   output logic                    csr_wen,
   output csr_bridge_pkg::csr_wr_t csr_wr
);

   typedef enum logic [2:0] {
      wr_idle      = 3'd0,
      wr_addr_rdy  = 3'd1,   // awready pulse
      wr_data_wait = 3'd2,
      wr_data_rdy  = 3'd3,   // wready and CSR write
      wr_resp      = 3'd4
   } wr_state_t;

   wr_state_t                                 state;
   wr_state_t                                 nstate;
   logic [csr_bridge_pkg::csr_addr_width-1:0] awaddr_q;
   logic [csr_bridge_pkg::id_width-1:0]       awid_q;
   logic                                      wr_hit;

   // --------------------------------------------------
   // State register and next state
   // --------------------------------------------------
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         state <= wr_idle;
      end
      else
      begin
         state <= nstate;
      end
   end

   always_comb
   begin
      nstate = state;
      if (csr_bridge_pkg::err_active(err))   // Abort from any error source
      begin
         nstate = wr_idle;
      end
      else
      begin
         case (state)
            wr_idle      : nstate = aw_valid_q ? wr_addr_rdy : wr_idle;
            wr_addr_rdy  : nstate = wr_data_wait;
            wr_data_wait : nstate = w_valid_q ? wr_data_rdy : wr_data_wait;
            wr_data_rdy  : nstate = wr_resp;
            wr_resp      : nstate = bready ? wr_idle : wr_resp;
            default      : nstate = wr_idle;
         endcase
      end
   end

   // Address and ID kept for the whole transaction
   always_ff @(posedge clk)
   begin
      if (aw_valid_q && awready)
      begin
         awaddr_q <= aw_q.addr[csr_bridge_pkg::csr_addr_width-1:0];
         awid_q   <= aw_q.id;
      end
   end

   // Only ctrl and cfg are writable
   assign wr_hit = (awaddr_q == csr_bridge_pkg::csr_addr_ctrl) ||
                   (awaddr_q == csr_bridge_pkg::csr_addr_cfg);

   // --------------------------------------------------
   // Outputs, registered from the next state
   // --------------------------------------------------
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         awready <= 1'b0;
         wready  <= 1'b0;
         bvalid  <= 1'b0;
         b       <= '0;
         csr_wen <= 1'b0;
         csr_wr  <= '0;
      end
      else
      begin
         awready <= (nstate == wr_addr_rdy);
         wready  <= (nstate == wr_data_rdy);
         bvalid  <= (nstate == wr_resp);
         b.id    <= (nstate == wr_resp) ? awid_q : '0;   // Held while bready is low
         csr_wen <= (nstate == wr_data_rdy) && wr_hit;
         if (nstate == wr_data_rdy)
         begin
            csr_wr.addr <= awaddr_q;
            csr_wr.data <= w_q.data;
            csr_wr.strb <= w_q.strb;
         end
         else
         begin
            csr_wr <= '0;
         end
      end
   end

endmodule

// File: csr_rd_fsm.sv
`timescale 1ns/100ps

module csr_rd_fsm #(
   parameter int csr_rd_latency = 1
) (
   input  logic                                      clk,
   input  logic                                      rst_n,
   input  csr_bridge_pkg::err_in_t                   err,
   input  logic                                      ar_valid_q,
   input  csr_bridge_pkg::ar_req_t                   ar_q,
   output logic                                      arready,
   input  logic                                      rready,
   output logic                                      rvalid,
   output csr_bridge_pkg::r_rsp_t                    r,
   output logic                                      csr_ren,
   output logic [csr_bridge_pkg::csr_addr_width-1:0] csr_raddr,
   input  logic [csr_bridge_pkg::data_width-1:0]     csr_rdata
);

   // Wait counter runs 0 .. csr_rd_latency-1
   localparam int cnt_width = (csr_rd_latency > 1) ? $clog2(csr_rd_latency) : 1;
   localparam logic [cnt_width-1:0] cnt_last = cnt_width'(csr_rd_latency - 1);

   typedef enum logic [2:0] {
      rd_idle      = 3'd0,
      rd_addr_rdy  = 3'd1,   // arready pulse
      rd_csr_en    = 3'd2,   // CSR read strobe
      rd_data_wait = 3'd3,
      rd_resp      = 3'd4
   } rd_state_t;

   rd_state_t                                 state;
   rd_state_t                                 nstate;
   logic [cnt_width-1:0]                      wait_cnt;
   logic [csr_bridge_pkg::csr_addr_width-1:0] araddr_q;
   logic [csr_bridge_pkg::id_width-1:0]       arid_q;
   logic [csr_bridge_pkg::data_width-1:0]     rdata_sel;

   function automatic logic rd_hit(input logic [csr_bridge_pkg::csr_addr_width-1:0] addr);
      return (addr == csr_bridge_pkg::csr_addr_ctrl) ||
             (addr == csr_bridge_pkg::csr_addr_stat) ||
             (addr == csr_bridge_pkg::csr_addr_cfg);
   endfunction

   // --------------------------------------------------
   // State register, wait count and next state
   // --------------------------------------------------
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         state    <= rd_idle;
         wait_cnt <= '0;
      end
      else
      begin
         state    <= nstate;
         wait_cnt <= (state == rd_data_wait) ? wait_cnt + cnt_width'(1) : '0;
      end
   end

   always_comb
   begin
      nstate = state;
      if (csr_bridge_pkg::err_active(err))
      begin
         nstate = rd_idle;
      end
      else
      begin
         case (state)
            rd_idle      : nstate = ar_valid_q ? rd_addr_rdy : rd_idle;
            rd_addr_rdy  : nstate = rd_csr_en;
            rd_csr_en    : nstate = rd_data_wait;
            rd_data_wait : nstate = (wait_cnt == cnt_last) ? rd_resp : rd_data_wait;
            rd_resp      : nstate = rready ? rd_idle : rd_resp;
            default      : nstate = rd_idle;
         endcase
      end
   end

   always_ff @(posedge clk)
   begin
      if (ar_valid_q && arready)
      begin
         araddr_q <= ar_q.addr[csr_bridge_pkg::csr_addr_width-1:0];
         arid_q   <= ar_q.id;
      end
   end

   // All ones above the window, zero for holes below it
   assign rdata_sel = (araddr_q > csr_bridge_pkg::csr_addr_cfg) ? '1 :
                      rd_hit(araddr_q) ? csr_rdata : '0;

   // --------------------------------------------------
   // Outputs
   // --------------------------------------------------
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         arready   <= 1'b0;
         rvalid    <= 1'b0;
         r         <= '0;
         csr_ren   <= 1'b0;
         csr_raddr <= '0;
      end
      else
      begin
         arready <= (nstate == rd_addr_rdy);
         rvalid  <= (nstate == rd_resp);
         // Address phase still held by the host here
         csr_ren   <= (nstate == rd_csr_en) &&
                      rd_hit(ar_q.addr[csr_bridge_pkg::csr_addr_width-1:0]);
         csr_raddr <= (nstate == rd_csr_en) ?
                      ar_q.addr[csr_bridge_pkg::csr_addr_width-1:0] : '0;
         if (nstate != rd_resp)
         begin
            r <= '0;
         end
         else if (state != rd_resp)   // Load once, hold under back-pressure
         begin
            r.data <= rdata_sel;
            r.id   <= arid_q;
         end
      end
   end

endmodule

// File: hps_csr_bridge.sv
`timescale 1ns/100ps

module hps_csr_bridge #(
   parameter int csr_rd_latency = 1
) (
   input  logic                                      clk,
   input  logic                                      rst_n,
   // Write address
   input  logic                                      awvalid,
   input  csr_bridge_pkg::aw_req_t                   aw,
   output logic                                      awready,
   // Write data
   input  logic                                      wvalid,
   input  csr_bridge_pkg::w_req_t                    w,
   output logic                                      wready,
   // Write response
   input  logic                                      bready,
   output logic                                      bvalid,
   output csr_bridge_pkg::b_rsp_t                    b,
   // Read address
   input  logic                                      arvalid,
   input  csr_bridge_pkg::ar_req_t                   ar,
   output logic                                      arready,
   // Read data
   input  logic                                      rready,
   output logic                                      rvalid,
   output csr_bridge_pkg::r_rsp_t                    r,
   // CSR block
   output logic                                      csr_wen,
   output csr_bridge_pkg::csr_wr_t                   csr_wr,
   output logic                                      csr_ren,
   output logic [csr_bridge_pkg::csr_addr_width-1:0] csr_raddr,
   input  logic [csr_bridge_pkg::data_width-1:0]     csr_rdata,
   input  csr_bridge_pkg::err_in_t                   err
);

   logic                    aw_valid_q;
   logic                    w_valid_q;
   logic                    ar_valid_q;
   csr_bridge_pkg::aw_req_t aw_q;
   csr_bridge_pkg::w_req_t  w_q;
   csr_bridge_pkg::ar_req_t ar_q;

   // --------------------------------------------------
   // Entry registers
   // --------------------------------------------------
   hps_rx_sample #(.payload_t(csr_bridge_pkg::aw_req_t)) aw_sample (
      .clk(clk), .rst_n(rst_n), .valid(awvalid), .payload(aw),
      .valid_q(aw_valid_q), .payload_q(aw_q)
   );

   hps_rx_sample #(.payload_t(csr_bridge_pkg::w_req_t)) w_sample (
      .clk(clk), .rst_n(rst_n), .valid(wvalid), .payload(w),
      .valid_q(w_valid_q), .payload_q(w_q)
   );

   hps_rx_sample #(.payload_t(csr_bridge_pkg::ar_req_t)) ar_sample (
      .clk(clk), .rst_n(rst_n), .valid(arvalid), .payload(ar),
      .valid_q(ar_valid_q), .payload_q(ar_q)
   );

   // Write and read channels run independently
   csr_wr_fsm wr_fsm (
      .clk(clk), .rst_n(rst_n), .err(err),
      .aw_valid_q(aw_valid_q), .aw_q(aw_q), .w_valid_q(w_valid_q), .w_q(w_q),
      .awready(awready), .wready(wready), .bready(bready), .bvalid(bvalid), .b(b),
      .csr_wen(csr_wen), .csr_wr(csr_wr)
   );

   csr_rd_fsm #(.csr_rd_latency(csr_rd_latency)) rd_fsm (
      .clk(clk), .rst_n(rst_n), .err(err),
      .ar_valid_q(ar_valid_q), .ar_q(ar_q), .arready(arready),
      .rready(rready), .rvalid(rvalid), .r(r),
      .csr_ren(csr_ren), .csr_raddr(csr_raddr), .csr_rdata(csr_rdata)
   );

endmodule

// File: hps_csr_bridge_properties.sv
`timescale 1ns/100ps

module hps_csr_bridge_properties (
   input logic                   clk,
   input logic                   rst_n,
   input logic                   awready,
   input logic                   wready,
   input logic                   bready,
   input logic                   bvalid,
   input csr_bridge_pkg::b_rsp_t b,
   input logic                   rready,
   input logic                   rvalid,
   input csr_bridge_pkg::r_rsp_t r,
   input logic                   csr_wen
);

   // Address and data ready come from different FSM states
   a_ready_excl : assert property (@(posedge clk) disable iff (!rst_n)
      !(awready && wready))
      else $error("awready and wready high in the same cycle");

   a_b_hold : assert property (@(posedge clk) disable iff (!rst_n)
      (bvalid && !bready) |=> (bvalid && $stable(b)))
      else $error("write response changed before bready");

   a_r_hold : assert property (@(posedge clk) disable iff (!rst_n)
      (rvalid && !rready) |=> (rvalid && $stable(r)))
      else $error("read response changed before rready");

   // CSR write strobe only in the data ready cycle
   a_wen_in_wready : assert property (@(posedge clk) disable iff (!rst_n)
      csr_wen |-> wready)
      else $error("csr_wen high without wready");

endmodule

bind hps_csr_bridge hps_csr_bridge_properties props (
   .clk(clk), .rst_n(rst_n), .awready(awready), .wready(wready),
   .bready(bready), .bvalid(bvalid), .b(b),
   .rready(rready), .rvalid(rvalid), .r(r), .csr_wen(csr_wen)
);

// File: tb_hps_csr_bridge.sv
`timescale 1ns/100ps

module tb_hps_csr_bridge;

   localparam int wait_limit     = 40;
   localparam int csr_rd_latency = 1;

   logic                    clk, rst_n;
   logic                    awvalid, awready, wvalid, wready, bready, bvalid;
   logic                    arvalid, arready, rready, rvalid;
   csr_bridge_pkg::aw_req_t aw;
   csr_bridge_pkg::w_req_t  w;
   csr_bridge_pkg::b_rsp_t  b;
   csr_bridge_pkg::ar_req_t ar;
   csr_bridge_pkg::r_rsp_t  r;
   logic                    csr_wen, csr_ren;
   csr_bridge_pkg::csr_wr_t csr_wr;
   logic [15:0]             csr_raddr;
   logic [31:0]             csr_rdata;
   csr_bridge_pkg::err_in_t err;

   logic [31:0] csr_mem [0:2];   // CSR block model
   logic [31:0] exp_mem [0:2];   // Contents the CSRs should hold
   logic [1:0]  rd_idx;
   int          seed;
   int          errors, errs_at_start, tests_run, tests_failed;
   int          wen_cnt, ren_cnt;

   hps_csr_bridge #(.csr_rd_latency(csr_rd_latency)) uut (.*);

   always #10 clk = ~clk;

   // --------------------------------------------------
   // CSR model with the read address latched on csr_ren
   // --------------------------------------------------
   assign csr_rdata = csr_mem[rd_idx];

   always @(posedge clk)
   begin
      if (csr_ren)
      begin
         rd_idx  <= csr_raddr[3:2];   // 0x150, 0x154, 0x158 map to 0, 1, 2
         ren_cnt <= ren_cnt + 1;
      end
      if (csr_wen)
      begin
         wen_cnt <= wen_cnt + 1;
         for (int i = 0; i < 4; i++)
            if (csr_wr.strb[i])
               csr_mem[csr_wr.addr[3:2]][8*i +: 8] <= csr_wr.data[8*i +: 8];
      end
   end

   // --------------------------------------------------
   // Checking helpers
   // --------------------------------------------------
   task automatic report_err(input string msg);
      $display("ERR %0t: %s", $time, msg);
      errors++;
   endtask

   task automatic compare_b(input csr_bridge_pkg::b_rsp_t got, exp);
      if (got !== exp)
         report_err($sformatf("bresp id %h, expected %h", got.id, exp.id));
   endtask

   task automatic compare_r(input csr_bridge_pkg::r_rsp_t got, exp);
      if (got !== exp)
         report_err($sformatf("rdata %h id %h, expected %h id %h",
                              got.data, got.id, exp.data, exp.id));
   endtask

   task automatic compare_csr_wr(input csr_bridge_pkg::csr_wr_t got, exp);
      if (got !== exp)
         report_err($sformatf("csr write %h/%h/%h, expected %h/%h/%h", got.addr,
                              got.data, got.strb, exp.addr, exp.data, exp.strb));
   endtask

   task automatic compare_num(input logic [31:0] got, input logic [31:0] exp,
                              input string what);
      if (got !== exp)
         report_err($sformatf("%s is %0d, expected %0d", what, got, exp));
   endtask

   task automatic timeout_fail(input string what);
      $display("Timed out at %0t waiting for %s from the DUT", $time, what);
      $display("** FAIL **");
      $finish;
   endtask

   function automatic logic probe(input string name);
      case (name)
         "awready" : return awready;
         "wready"  : return wready;
         "bvalid"  : return bvalid;
         "arready" : return arready;
         "rvalid"  : return rvalid;
         default   : return 1'bx;
      endcase
   endfunction

   // Outputs are read at the edge before the DUT updates them
   task automatic wait_high(input string name);
      int n;
      n = 0;
      do
      begin
         @(posedge clk);
         n++;
      end
      while (probe(name) !== 1'b1 && n < wait_limit);
      if (probe(name) !== 1'b1)
         timeout_fail(name);
   endtask

   // --------------------------------------------------
   // Transactions
   // --------------------------------------------------
   task automatic do_write(input logic [20:0] addr, input logic [3:0] id,
                           input logic [31:0] data, input logic [3:0] strb, input int stall);
      csr_bridge_pkg::csr_wr_t exp_wr;
      csr_bridge_pkg::b_rsp_t  exp_b;
      logic                    hit;
      int                      wen0;
      hit         = (addr[15:0] == 16'h0150) || (addr[15:0] == 16'h0158);
      exp_wr.addr = addr[15:0];
      exp_wr.data = data;
      exp_wr.strb = strb;
      exp_b.id    = id;
      wen0        = wen_cnt;
      aw      <= {addr, id};
      awvalid <= 1'b1;
      bready  <= (stall == 0);
      wait_high("awready");
      awvalid <= 1'b0;
      w       <= {data, strb};
      wvalid  <= 1'b1;
      wait_high("wready");
      compare_csr_wr(csr_wr, exp_wr);
      compare_num(csr_wen, hit, "csr_wen with wready");
      wvalid <= 1'b0;
      wait_high("bvalid");
      compare_b(b, exp_b);
      if (stall > 0)
      begin
         repeat (stall)
         begin
            @(posedge clk);
            compare_num(bvalid, 1, "bvalid under back-pressure");
            compare_b(b, exp_b);
         end
         bready <= 1'b1;
         @(posedge clk);   // Handshake edge
         compare_num(bvalid, 1, "bvalid at handshake");
         compare_b(b, exp_b);
      end
      @(posedge clk);
      compare_num(bvalid, 0, "bvalid after handshake");
      compare_num(wen_cnt - wen0, hit, "csr_wen pulses");
      if (hit)
         for (int i = 0; i < 4; i++)
            if (strb[i])
               exp_mem[addr[3:2]][8*i +: 8] = data[8*i +: 8];
   endtask

   task automatic do_read(input logic [20:0] addr, input logic [3:0] id, input int stall);
      csr_bridge_pkg::r_rsp_t exp_r;
      logic [15:0]            a16;
      logic                   hit;
      int                     ren0;
      a16        = addr[15:0];
      hit        = (a16 == 16'h0150) || (a16 == 16'h0154) || (a16 == 16'h0158);
      exp_r.id   = id;
      exp_r.data = (a16 > 16'h0158) ? 32'hffff_ffff : (hit ? exp_mem[a16[3:2]] : 32'h0);
      ren0       = ren_cnt;
      ar      <= {addr, id};
      arvalid <= 1'b1;
      rready  <= (stall == 0);
      wait_high("arready");
      arvalid <= 1'b0;
      @(posedge clk);   // Strobe cycle follows arready
      compare_num(csr_ren, hit, "csr_ren");
      compare_num(csr_raddr, a16, "csr_raddr");
      wait_high("rvalid");
      compare_r(r, exp_r);
      if (stall > 0)
      begin
         repeat (stall)
         begin
            @(posedge clk);
            compare_num(rvalid, 1, "rvalid under back-pressure");
            compare_r(r, exp_r);
         end
         rready <= 1'b1;
         @(posedge clk);
         compare_num(rvalid, 1, "rvalid at handshake");
         compare_r(r, exp_r);
      end
      @(posedge clk);
      compare_num(rvalid, 0, "rvalid after handshake");
      compare_num(ren_cnt - ren0, hit, "csr_ren pulses");
   endtask

   // Error pulse lands in data wait so nothing may follow
   task automatic abort_write(input csr_bridge_pkg::err_in_t e);
      int wen0;
      wen0    = wen_cnt;
      aw      <= {21'h00150, 4'h5};
      awvalid <= 1'b1;
      wait_high("awready");
      awvalid <= 1'b0;
      err     <= e;
      @(posedge clk);
      err    <= '0;
      w      <= {32'hdead_0150, 4'hf};
      wvalid <= 1'b1;
      for (int i = 0; i < 10; i++)
      begin
         @(posedge clk);
         if (i == 2)
            wvalid <= 1'b0;
         compare_num(wready | bvalid, 0, "wready or bvalid after abort");
      end
      compare_num(wen_cnt - wen0, 0, "csr_wen pulses after abort");
   endtask

   task automatic finish_test(input string name);
      tests_run++;
      if (errors != errs_at_start)
      begin
         tests_failed++;
         $display("test %s: failed with %0d errors", name, errors - errs_at_start);
      end
      else
         $display("test %s: ok", name);
      errs_at_start = errors;
   endtask

   // --------------------------------------------------
   // Directed tests
   // --------------------------------------------------
   task automatic test_write_mapped();
      do_write(21'h00150, 4'($random(seed)), $random(seed), 4'hf, 0);
      do_write(21'h10158, 4'($random(seed)), $random(seed), 4'b0101, 0);   // Upper bits ignored
   endtask

   task automatic test_write_unmapped();
      do_write(21'h00154, 4'($random(seed)), $random(seed), 4'hf, 0);
      do_write(21'h00200, 4'($random(seed)), $random(seed), 4'hf, 0);
   endtask

   task automatic test_read_mapped();
      do_read(21'h00150, 4'($random(seed)), 0);
      do_read(21'h00154, 4'($random(seed)), 0);
      do_read(21'h00158, 4'($random(seed)), 0);
   endtask

   task automatic test_read_outside();
      do_read(21'h0015c, 4'($random(seed)), 0);
      do_read(21'h1f000, 4'($random(seed)), 0);
      do_read(21'h0014c, 4'($random(seed)), 0);
   endtask

   task automatic test_back_pressure();
      do_write(21'h00150, 4'($random(seed)), $random(seed), 4'hf, 1 + {$random(seed)} % 6);
      do_read(21'h00150, 4'($random(seed)), 1 + {$random(seed)} % 6);
      do_write(21'h00158, 4'($random(seed)), $random(seed), 4'b1100, 0);
      do_read(21'h00158, 4'($random(seed)), 0);
   endtask

   task automatic test_abort();
      abort_write(4'b1000);   // Completion error
      abort_write(4'b0100);   // FIFO error
      abort_write(4'b0010);   // Transmit write response
      do_write(21'h00150, 4'($random(seed)), $random(seed), 4'hf, 0);
      do_read(21'h00150, 4'($random(seed)), 0);
   endtask

   initial
   begin
      clk     = 1'b0;
      rst_n   = 1'b0;
      awvalid = 1'b0;
      aw      = '0;
      wvalid  = 1'b0;
      w       = '0;
      bready  = 1'b1;
      arvalid = 1'b0;
      ar      = '0;
      rready  = 1'b1;
      err     = '0;
      rd_idx  = 2'd0;
      seed    = 37294;
      errors  = 0;
      errs_at_start = 0;
      tests_run     = 0;
      tests_failed  = 0;
      wen_cnt = 0;
      ren_cnt = 0;
      for (int i = 0; i < 3; i++)
      begin
         csr_mem[i] = {16'hc5a0, 16'h0150 + 16'(4 * i)};
         exp_mem[i] = {16'hc5a0, 16'h0150 + 16'(4 * i)};
      end
      repeat (2) @(posedge clk);
      rst_n <= 1'b1;
      @(posedge clk);
      compare_num({awready, wready, bvalid, arready, rvalid, csr_wen, csr_ren}, 0,
                  "handshake outputs after reset");
      finish_test("reset");
      test_write_mapped();
      finish_test("write_mapped");
      test_write_unmapped();
      finish_test("write_unmapped");
      test_read_mapped();
      finish_test("read_mapped");
      test_read_outside();
      finish_test("read_outside");
      test_back_pressure();
      finish_test("back_pressure");
      test_abort();
      finish_test("abort");
      $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
      if (errors == 0)
         $display("** PASS **");
      else
         $display("** FAIL **");
      $finish;
   end

endmodule

// File: files.f
csr_bridge_pkg.sv
hps_rx_sample.sv
csr_wr_fsm.sv
csr_rd_fsm.sv
hps_csr_bridge.sv
hps_csr_bridge_properties.sv
tb_hps_csr_bridge.sv
